//--- common/asg_pkg.sv
//////////////////////////////////////////////////
// shared constants for the signal generator
// offsets are bytes inside a 64 byte register window
// bus data is fixed at 32 bits
//////////////////////////////////////////////////

package asg_pkg;

  localparam int unsigned AW     = 16;  // bus byte address width
  localparam int unsigned DW_BUS = 32;  // bus data width
  localparam int unsigned RAW    = 6;   // register offset width

  //////////////////////////////////////////////////
  // channel register offsets
  //////////////////////////////////////////////////

  localparam logic [RAW-1:0] REG_CTL     = 6'h00;  // rst, trg, run state
  localparam logic [RAW-1:0] REG_TRG     = 6'h04;  // ext trigger mask
  localparam logic [RAW-1:0] REG_SIZ     = 6'h10;  // table size, fixed point
  localparam logic [RAW-1:0] REG_OFF     = 6'h14;  // start offset (phase)
  localparam logic [RAW-1:0] REG_STP     = 6'h18;  // step (frequency)
  localparam logic [RAW-1:0] REG_BST     = 6'h20;  // burst enable, infinite
  localparam logic [RAW-1:0] REG_BDL     = 6'h24;  // burst data length
  localparam logic [RAW-1:0] REG_BLN     = 6'h28;  // burst idle length
  localparam logic [RAW-1:0] REG_BNM     = 6'h2c;  // burst repetitions
  localparam logic [RAW-1:0] REG_STS_BLN = 6'h30;  // phase cycle counter
  localparam logic [RAW-1:0] REG_STS_BNM = 6'h34;  // repetition counter
  localparam logic [RAW-1:0] REG_MUL     = 6'h38;  // gain
  localparam logic [RAW-1:0] REG_SUM     = 6'h3c;  // offset

  // control word, meaning depends on the offset written
  typedef struct packed {
    logic [DW_BUS-3:0] rsv;
    logic              trg;  // software trigger
    logic              rst;  // software stop
  } ctl_view_t;

  typedef struct packed {
    logic [DW_BUS-3:0] rsv;
    logic              inf;  // repeat forever
    logic              ben;  // burst mode
  } bst_view_t;

  typedef union packed {
    ctl_view_t ctl;  // at REG_CTL
    bst_view_t bst;  // at REG_BST
  } ctl_word_t;

endpackage

//--- verilog/asg_bus_decode.sv
//////////////////////////////////////////////////
// bus address decoder, purely combinational
// channel index sits above the region bit CWM+2
// index CHN is the global region, larger ones hit nothing
//////////////////////////////////////////////////
`timescale 1ns/1ps

module asg_bus_decode #(
  parameter int unsigned CHN = 3,
  parameter int unsigned CWM = 8
) (
  input  logic                       bus_wen,
  input  logic                       bus_ren,
  input  logic [asg_pkg::AW-1:0]     bus_addr,
  input  logic [asg_pkg::DW_BUS-1:0] bus_wdata,
  output logic [CHN-1:0]             ch_wen,
  output logic [CHN-1:0]             ch_ren,
  output logic                       glb_wen,
  output logic                       glb_ren,
  output logic                       buf_sel,
  output logic [asg_pkg::RAW-1:0]    reg_addr,
  output logic [CWM-1:0]             buf_addr,
  output logic [asg_pkg::DW_BUS-1:0] wdata,
  output logic                       ack_req
);

  import asg_pkg::*;

  localparam int unsigned IW = AW - CWM - 3;  // channel index bits

  logic [IW-1:0] idx;
  logic          glb;

  assign idx = bus_addr[AW-1:CWM+3];
  assign glb = (idx == IW'(CHN));

  // one-hot per channel, out of range index gives zero
  assign ch_wen  = bus_wen ? CHN'(1) << idx : '0;
  assign ch_ren  = bus_ren ? CHN'(1) << idx : '0;
  assign glb_wen = bus_wen & glb;
  assign glb_ren = bus_ren & glb;

  assign buf_sel  = bus_addr[CWM+2];     // 1: table, 0: registers
  assign reg_addr = bus_addr[RAW-1:0];
  assign buf_addr = bus_addr[CWM+1:2];   // word address
  assign wdata    = bus_wdata;
  assign ack_req  = bus_wen | bus_ren;   // every strobe is acked

endmodule

//--- verilog/asg_bus_return.sv
//////////////////////////////////////////////////
// read data return and interrupt collection
// ack is always one cycle after the strobe, no errors
// pending layout: bit 2i trg, bit 2i+1 stp of channel i
//////////////////////////////////////////////////
`timescale 1ns/1ps

module asg_bus_return #(
  parameter int unsigned CHN = 3
) (
  input  logic                       bus,
  input  logic                       arst_n,
  input  logic [CHN-1:0]             ch_ren,
  input  logic                       glb_ren,
  input  logic                       glb_wen,
  input  logic [asg_pkg::DW_BUS-1:0] wdata,
  input  logic                       ack_req,
  input  logic [asg_pkg::DW_BUS-1:0] ch_rdata [CHN],
  input  logic [CHN-1:0]             irq_trg,
  input  logic [CHN-1:0]             irq_stp,
  output logic [asg_pkg::DW_BUS-1:0] bus_rdata,
  output logic                       bus_ack,
  output logic                       irq
);

  import asg_pkg::*;

  logic [2*CHN-1:0] pnd;      // sticky pending bits
  logic [2*CHN-1:0] pnd_set;
  logic [2*CHN-1:0] pnd_clr;
  logic [CHN-1:0]   ren_q;    // read select, one cycle late
  logic             glb_q;

  always_comb begin
    for (int i = 0; i < CHN; i++) begin
      pnd_set[2*i]   = irq_trg[i];
      pnd_set[2*i+1] = irq_stp[i];
    end
  end

  assign pnd_clr = glb_wen ? wdata[2*CHN-1:0] : '0;  // write one to clear

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      pnd     <= '0;
      ren_q   <= '0;
      glb_q   <= 1'b0;
      bus_ack <= 1'b0;
    end else begin
      pnd     <= (pnd & ~pnd_clr) | pnd_set;  // new event beats clear
      ren_q   <= ch_ren;
      glb_q   <= glb_ren;
      bus_ack <= ack_req;
    end
  end

  // channels already register their data, just pick one
  always_comb begin
    bus_rdata = glb_q ? DW_BUS'(pnd) : '0;
    for (int i = 0; i < CHN; i++) begin
      if (ren_q[i]) bus_rdata = bus_rdata | ch_rdata[i];
    end
  end

  assign irq = |pnd;

endmodule

//--- asg_channel/asg_ch_regs.sv
//////////////////////////////////////////////////
// channel configuration registers and readback
// writes land on the next clock, rst beats trg
// gain resets to unity, 2**(DW-2)
//////////////////////////////////////////////////
`timescale 1ns/1ps

module asg_ch_regs #(
  parameter int unsigned CWM = 8,
  parameter int unsigned CWF = 16,
  parameter int unsigned DW  = 14,
  parameter int unsigned TN  = 4
) (
  input  logic                       bus,
  input  logic                       arst_n,
  input  logic                       wen,
  input  logic                       ren,
  input  logic [asg_pkg::RAW-1:0]    reg_addr,
  input  logic [asg_pkg::DW_BUS-1:0] wdata,
  input  logic                       sts_run,
  input  logic [asg_pkg::DW_BUS-1:0] sts_bln,
  input  logic [15:0]                sts_bnm,
  input  logic signed [DW-1:0]       tbl_rdata,
  input  logic                       buf_sel,
  output logic [asg_pkg::DW_BUS-1:0] rdata,
  output logic                       ctl_rst,
  output logic                       ctl_trg,
  output logic [TN-1:0]              cfg_trg,
  output logic [CWM+CWF-1:0]         cfg_siz,
  output logic [CWM+CWF-1:0]         cfg_off,
  output logic [CWM+CWF-1:0]         cfg_stp,
  output logic                       cfg_ben,
  output logic                       cfg_inf,
  output logic [CWM-1:0]             cfg_bdl,
  output logic [asg_pkg::DW_BUS-1:0] cfg_bln,
  output logic [15:0]                cfg_bnm,
  output logic signed [DW-1:0]       cfg_mul,
  output logic signed [DW-1:0]       cfg_sum
);

  import asg_pkg::*;

  ctl_word_t         wd;      // write word, ctl or bst view
  logic              reg_we;
  logic              buf_q;   // last read went to the table
  logic [DW_BUS-1:0] reg_q;   // register readback

  assign wd     = ctl_word_t'(wdata);
  assign reg_we = wen & ~buf_sel;

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      ctl_rst <= 1'b0;
      ctl_trg <= 1'b0;
      cfg_trg <= '0;
      cfg_siz <= '0;
      cfg_off <= '0;
      cfg_stp <= '0;
      cfg_ben <= 1'b0;
      cfg_inf <= 1'b0;
      cfg_bdl <= '0;
      cfg_bln <= '0;
      cfg_bnm <= '0;
      cfg_mul <= DW'(1) << (DW - 2);  // unity gain
      cfg_sum <= '0;
    end else begin
      // one cycle pulses
      ctl_rst <= reg_we && reg_addr == REG_CTL && wd.ctl.rst;
      ctl_trg <= reg_we && reg_addr == REG_CTL && wd.ctl.trg && !wd.ctl.rst;
      if (reg_we) begin
        case (reg_addr)
          REG_TRG: cfg_trg <= wdata[TN-1:0];
          REG_SIZ: cfg_siz <= wdata[CWM+CWF-1:0];
          REG_OFF: cfg_off <= wdata[CWM+CWF-1:0];
          REG_STP: cfg_stp <= wdata[CWM+CWF-1:0];
          REG_BST: begin
            cfg_ben <= wd.bst.ben;
            cfg_inf <= wd.bst.inf;
          end
          REG_BDL: cfg_bdl <= wdata[CWM-1:0];
          REG_BLN: cfg_bln <= wdata;
          REG_BNM: cfg_bnm <= wdata[15:0];
          REG_MUL: cfg_mul <= wdata[DW-1:0];
          REG_SUM: cfg_sum <= wdata[DW-1:0];
          default: ;  // status and CTL have no flops here
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n)  buf_q <= 1'b0;
    else if (ren) buf_q <= buf_sel;
  end

  always_ff @(posedge bus) begin
    if (ren && !buf_sel) begin
      case (reg_addr)
        REG_CTL:     reg_q <= DW_BUS'({~sts_run, sts_run, 2'b00});
        REG_TRG:     reg_q <= DW_BUS'(cfg_trg);
        REG_SIZ:     reg_q <= DW_BUS'(cfg_siz);
        REG_OFF:     reg_q <= DW_BUS'(cfg_off);
        REG_STP:     reg_q <= DW_BUS'(cfg_stp);
        REG_BST:     reg_q <= DW_BUS'({cfg_inf, cfg_ben});
        REG_BDL:     reg_q <= DW_BUS'(cfg_bdl);
        REG_BLN:     reg_q <= cfg_bln;
        REG_BNM:     reg_q <= DW_BUS'(cfg_bnm);
        REG_STS_BLN: reg_q <= sts_bln;
        REG_STS_BNM: reg_q <= DW_BUS'(sts_bnm);
        REG_MUL:     reg_q <= DW_BUS'(cfg_mul);  // sign extended
        REG_SUM:     reg_q <= DW_BUS'(cfg_sum);
        default:     reg_q <= '0;
      endcase
    end
  end

  assign rdata = buf_q ? DW_BUS'(tbl_rdata) : reg_q;  // table words sign extended

endmodule

//--- asg_channel/asg_ch_gen.sv
//////////////////////////////////////////////////
// table pointer and burst sequencer
// triggers only count while stopped
// bdl of 0 acts as 1, bnm of 0 as 1 repetition
//////////////////////////////////////////////////
`timescale 1ns/1ps

module asg_ch_gen #(
  parameter int unsigned CWM = 8,
  parameter int unsigned CWF = 16,
  parameter int unsigned TN  = 4
) (
  input  logic                       bus,
  input  logic                       arst_n,
  input  logic                       ctl_rst,
  input  logic                       ctl_trg,
  input  logic [TN-1:0]              trg_ext,
  input  logic [TN-1:0]              cfg_trg,
  input  logic [CWM+CWF-1:0]         cfg_siz,
  input  logic [CWM+CWF-1:0]         cfg_off,
  input  logic [CWM+CWF-1:0]         cfg_stp,
  input  logic                       cfg_ben,
  input  logic                       cfg_inf,
  input  logic [CWM-1:0]             cfg_bdl,
  input  logic [asg_pkg::DW_BUS-1:0] cfg_bln,
  input  logic [15:0]                cfg_bnm,
  output logic [CWM-1:0]             tbl_addr,
  output logic                       smp_vld,
  output logic                       sts_run,
  output logic [asg_pkg::DW_BUS-1:0] sts_bln,
  output logic [15:0]                sts_bnm,
  output logic                       trg_out,
  output logic                       irq_trg,
  output logic                       irq_stp
);

  import asg_pkg::*;

  localparam int unsigned PW = CWM + CWF;  // pointer width

  typedef enum logic [1:0] {ST_STOP, ST_DATA, ST_IDLE} state_t;

  state_t        state;
  logic [PW-1:0] ptr;               // fixed point table pointer
  logic [PW:0]   ptr_add, ptr_wrp;  // one spare bit for the wrap compare
  logic [TN-1:0] trg_q;
  logic          ext_edge, start, dat_end, rep_end, last_rep;

  assign ext_edge = |(trg_ext & ~trg_q & cfg_trg);  // unmasked rising edges
  assign start    = (state == ST_STOP) & (ctl_trg | ext_edge) & ~ctl_rst;

  assign ptr_add = {1'b0, ptr} + {1'b0, cfg_stp};
  assign ptr_wrp = (ptr_add >= {1'b0, cfg_siz}) ? ptr_add - {1'b0, cfg_siz} : ptr_add;

  // burst phase ends
  assign dat_end  = (state == ST_DATA) & cfg_ben & (sts_bln + 1'b1 >= DW_BUS'(cfg_bdl));
  assign rep_end  = (state == ST_IDLE) & (sts_bln + 1'b1 >= cfg_bln)
                  | dat_end & (cfg_bln == '0);  // no idle gap
  assign last_rep = ~cfg_inf & (sts_bnm + 16'd1 >= cfg_bnm);

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_STOP;
      ptr     <= '0;
      sts_bln <= '0;
      sts_bnm <= '0;
      trg_q   <= '0;
      trg_out <= 1'b0;
      irq_trg <= 1'b0;
      irq_stp <= 1'b0;
    end else begin
      trg_q   <= trg_ext;
      trg_out <= start;  // high in the first data cycle
      irq_trg <= start;
      irq_stp <= rep_end & last_rep & ~ctl_rst;
      if (ctl_rst) begin
        state <= ST_STOP;  // software stop, no irq
      end else if (start) begin
        state   <= ST_DATA;
        ptr     <= cfg_off;
        sts_bln <= '0;
        sts_bnm <= '0;
      end else if (rep_end) begin
        state   <= last_rep ? ST_STOP : ST_DATA;
        ptr     <= cfg_off;  // each repetition restarts at the offset
        sts_bln <= '0;
        sts_bnm <= sts_bnm + 16'd1;
      end else if (dat_end) begin
        state   <= ST_IDLE;
        sts_bln <= '0;
      end else if (state != ST_STOP) begin
        sts_bln <= sts_bln + 1'b1;
        if (state == ST_DATA) ptr <= ptr_wrp[PW-1:0];
      end
    end
  end

  assign tbl_addr = ptr[CWF+:CWM];  // integer part
  assign smp_vld  = (state == ST_DATA);
  assign sts_run  = (state != ST_STOP);

endmodule

//--- asg_channel/asg_ch_lin.sv
//////////////////////////////////////////////////
// gain and offset, two register stages
// out = sat(smp * mul >>> (DW-2) + sum)
//////////////////////////////////////////////////
`timescale 1ns/1ps

module asg_ch_lin #(
  parameter int unsigned DW = 14
) (
  input  logic                 bus,
  input  logic                 arst_n,
  input  logic                 smp_vld,
  input  logic signed [DW-1:0] smp_dat,
  input  logic signed [DW-1:0] cfg_mul,
  input  logic signed [DW-1:0] cfg_sum,
  output logic signed [DW-1:0] dac_dat,
  output logic                 dac_vld
);

  localparam int SMAX = 2**(DW-1) - 1;  // signed range limits
  localparam int SMIN = -(2**(DW-1));

  logic signed [2*DW-1:0] prd;
  logic signed [DW+1:0]   prd_q;  // scaled product, 2 guard bits
  logic signed [DW+2:0]   sum;
  logic signed [DW-1:0]   sat;
  logic                   vld_q;

  assign prd = smp_dat * cfg_mul;
  assign sum = prd_q + cfg_sum;
  assign sat = (sum > SMAX) ? DW'(SMAX) : (sum < SMIN) ? DW'(SMIN) : sum[DW-1:0];

  // multiply stage, data payload only
  always_ff @(posedge bus) begin
    prd_q <= prd[2*DW-1:DW-2];  // >>> (DW-2)
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      vld_q   <= 1'b0;
      dac_vld <= 1'b0;
      dac_dat <= '0;
    end else begin
      vld_q   <= smp_vld;
      dac_vld <= vld_q;
      dac_dat <= vld_q ? sat : '0;  // zero while idle or stopped
    end
  end

endmodule

//--- asg_channel/asg_channel.sv
//////////////////////////////////////////////////
// one generator channel with its waveform table
// table is one write and two registered read ports
// table contents have no reset
//////////////////////////////////////////////////
`timescale 1ns/1ps

module asg_channel #(
  parameter int unsigned CWM = 8,
  parameter int unsigned CWF = 16,
  parameter int unsigned DW  = 14,
  parameter int unsigned TN  = 4
) (
  input  logic                       bus,
  input  logic                       arst_n,
  input  logic                       wen,
  input  logic                       ren,
  input  logic                       buf_sel,
  input  logic [asg_pkg::RAW-1:0]    reg_addr,
  input  logic [CWM-1:0]             buf_addr,
  input  logic [asg_pkg::DW_BUS-1:0] wdata,
  input  logic [TN-1:0]              trg_ext,
  output logic [asg_pkg::DW_BUS-1:0] rdata,
  output logic signed [DW-1:0]       dac_dat,
  output logic                       dac_vld,
  output logic                       trg_out,
  output logic                       irq_trg,
  output logic                       irq_stp
);

  import asg_pkg::*;

  logic signed [DW-1:0] tbl [2**CWM];  // waveform table
  logic signed [DW-1:0] tbl_rdata;     // bus read port
  logic signed [DW-1:0] smp_dat;       // generator read port
  logic                 smp_vld, smp_vld_q;
  logic [CWM-1:0]       tbl_addr;

  logic                 ctl_rst, ctl_trg, cfg_ben, cfg_inf, sts_run;
  logic [TN-1:0]        cfg_trg;
  logic [CWM+CWF-1:0]   cfg_siz, cfg_off, cfg_stp;
  logic [CWM-1:0]       cfg_bdl;
  logic [DW_BUS-1:0]    cfg_bln, sts_bln;
  logic [15:0]          cfg_bnm, sts_bnm;
  logic signed [DW-1:0] cfg_mul, cfg_sum;

  always_ff @(posedge bus) begin
    if (wen && buf_sel) tbl[buf_addr] <= wdata[DW-1:0];
    tbl_rdata <= tbl[buf_addr];
    smp_dat   <= tbl[tbl_addr];  // first pipeline stage
  end

  // valid follows the table read
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) smp_vld_q <= 1'b0;
    else         smp_vld_q <= smp_vld;
  end

  asg_ch_regs #(.CWM(CWM), .CWF(CWF), .DW(DW), .TN(TN)) regs_i (
    .bus, .arst_n, .wen, .ren, .reg_addr, .wdata,
    .sts_run, .sts_bln, .sts_bnm, .tbl_rdata, .buf_sel,
    .rdata, .ctl_rst, .ctl_trg, .cfg_trg, .cfg_siz, .cfg_off, .cfg_stp,
    .cfg_ben, .cfg_inf, .cfg_bdl, .cfg_bln, .cfg_bnm, .cfg_mul, .cfg_sum
  );

  asg_ch_gen #(.CWM(CWM), .CWF(CWF), .TN(TN)) gen_i (
    .bus, .arst_n, .ctl_rst, .ctl_trg, .trg_ext,
    .cfg_trg, .cfg_siz, .cfg_off, .cfg_stp,
    .cfg_ben, .cfg_inf, .cfg_bdl, .cfg_bln, .cfg_bnm,
    .tbl_addr, .smp_vld, .sts_run, .sts_bln, .sts_bnm,
    .trg_out, .irq_trg, .irq_stp
  );

  asg_ch_lin #(.DW(DW)) lin_i (
    .bus, .arst_n, .smp_vld(smp_vld_q), .smp_dat,
    .cfg_mul, .cfg_sum, .dac_dat, .dac_vld
  );

endmodule

//--- verilog/asg_top.sv
//////////////////////////////////////////////////
// multi channel arbitrary signal generator
// register bus with plain strobes and a one cycle ack
// DAC words are levels with a valid strobe, no backpressure
//////////////////////////////////////////////////
`timescale 1ns/1ps

module asg_top #(
  parameter int unsigned CHN = 3,   // channels
  parameter int unsigned CWM = 8,   // table address bits
  parameter int unsigned CWF = 16,  // pointer fraction bits
  parameter int unsigned DW  = 14,  // sample width, signed
  parameter int unsigned TN  = 4    // external triggers
) (
  input  logic                       bus,
  input  logic                       arst_n,
  input  logic                       bus_wen,
  input  logic                       bus_ren,
  input  logic [asg_pkg::AW-1:0]     bus_addr,
  input  logic [asg_pkg::DW_BUS-1:0] bus_wdata,
  input  logic [TN-1:0]              trg_ext,
  output logic [asg_pkg::DW_BUS-1:0] bus_rdata,
  output logic                       bus_ack,
  output logic signed [DW-1:0]       dac_dat [CHN],
  output logic [CHN-1:0]             dac_vld,
  output logic [CHN-1:0]             trg_out,
  output logic                       irq
);

  import asg_pkg::*;

  logic [CHN-1:0]    ch_wen, ch_ren;
  logic              glb_wen, glb_ren, buf_sel, ack_req;
  logic [RAW-1:0]    reg_addr;
  logic [CWM-1:0]    buf_addr;
  logic [DW_BUS-1:0] wdata;
  logic [DW_BUS-1:0] ch_rdata [CHN];
  logic [CHN-1:0]    irq_trg, irq_stp;

  asg_bus_decode #(.CHN(CHN), .CWM(CWM)) dec_i (
    .bus_wen, .bus_ren, .bus_addr, .bus_wdata,
    .ch_wen, .ch_ren, .glb_wen, .glb_ren, .buf_sel,
    .reg_addr, .buf_addr, .wdata, .ack_req
  );

  for (genvar i = 0; i < CHN; i++) begin : g_ch
    asg_channel #(.CWM(CWM), .CWF(CWF), .DW(DW), .TN(TN)) ch_i (
      .bus, .arst_n,
      .wen(ch_wen[i]), .ren(ch_ren[i]),
      .buf_sel, .reg_addr, .buf_addr, .wdata, .trg_ext,
      .rdata(ch_rdata[i]), .dac_dat(dac_dat[i]), .dac_vld(dac_vld[i]),
      .trg_out(trg_out[i]), .irq_trg(irq_trg[i]), .irq_stp(irq_stp[i])
    );
  end

  asg_bus_return #(.CHN(CHN)) ret_i (
    .bus, .arst_n, .ch_ren, .glb_ren, .glb_wen, .wdata, .ack_req,
    .ch_rdata, .irq_trg, .irq_stp, .bus_rdata, .bus_ack, .irq
  );

endmodule

//--- test/asg_asserts.sv
//////////////////////////////////////////////////
// bus ack and interrupt checks, bound into the return block
//////////////////////////////////////////////////
`timescale 1ns/1ps

module asg_asserts #(
  parameter int unsigned CHN = 3
) (
  input logic                       bus,
  input logic                       arst_n,
  input logic [CHN-1:0]             ch_ren,
  input logic                       glb_ren,
  input logic                       glb_wen,
  input logic [asg_pkg::DW_BUS-1:0] wdata,
  input logic                       bus_ack,
  input logic [CHN-1:0]             irq_trg,
  input logic [CHN-1:0]             irq_stp,
  input logic                       irq
);

  // decoded strobes get their ack one cycle later
  ack_after_req: assert property (@(posedge bus) disable iff (!arst_n)
    (|ch_ren || glb_ren || glb_wen) |=> bus_ack)
    else $error("bus_ack missing after a strobe");

  // any trigger or stop pulse leaves irq raised
  irq_on_event: assert property (@(posedge bus) disable iff (!arst_n)
    (|irq_trg || |irq_stp) |=> irq)
    else $error("irq stayed low after an interrupt pulse");

  // all bits cleared and nothing new, irq must drop
  irq_cleared: assert property (@(posedge bus) disable iff (!arst_n)
    (glb_wen && (&wdata[2*CHN-1:0]) && !(|irq_trg) && !(|irq_stp)) |=> !irq)
    else $error("irq still high after all pending bits were cleared");

endmodule

bind asg_bus_return asg_asserts #(.CHN(CHN)) asrt_i (
  .bus(bus), .arst_n(arst_n), .ch_ren(ch_ren), .glb_ren(glb_ren),
  .glb_wen(glb_wen), .wdata(wdata), .bus_ack(bus_ack),
  .irq_trg(irq_trg), .irq_stp(irq_stp), .irq(irq)
);

//--- test/asg_tb.sv
//////////////////////////////////////////////////
// directed testbench for the signal generator
// inputs change on the falling edge, outputs are sampled there
// playback runs on channel 0, channels 1 and 2 stay idle
//////////////////////////////////////////////////
`timescale 1ns/1ps

module asg_tb;

  import asg_pkg::*;

  localparam int CHN   = 3;
  localparam int CWM   = 8;
  localparam int CWF   = 16;
  localparam int DW    = 14;
  localparam int TN    = 4;
  localparam int UNITY = 2**(DW-2);  // gain of 1.0
  // table pass costs 4 cycles per word, playback tests well under 400 each
  localparam int MAX_CYC = CHN * 4 * (10 + 2**CWM) + 6 * 400 + 16;

  logic                 bus, arst_n, bus_wen, bus_ren, bus_ack, irq;
  logic [AW-1:0]        bus_addr;
  logic [DW_BUS-1:0]    bus_wdata, bus_rdata;
  logic [TN-1:0]        trg_ext;
  logic signed [DW-1:0] dac_dat [CHN];
  logic [CHN-1:0]       dac_vld, trg_out;

  logic signed [DW-1:0] tbl_mdl [CHN][2**CWM];  // expected table contents
  logic signed [DW-1:0] exp_dat [$];            // expected DAC stream
  logic                 exp_vld [$];
  logic [RAW-1:0]       rw_regs [10];           // writable registers
  logic [31:0]          lfsr;
  int                   n_chk, n_err, cyc, other_act;
  int                   trg_cnt [CHN];

  asg_top #(.CHN(CHN), .CWM(CWM), .CWF(CWF), .DW(DW), .TN(TN)) dut_i (
    .bus, .arst_n, .bus_wen, .bus_ren, .bus_addr, .bus_wdata, .trg_ext,
    .bus_rdata, .bus_ack, .dac_dat, .dac_vld, .trg_out, .irq
  );

  always #5 bus = ~bus;  // 10 ns period

  // trigger pulses per channel, and any sign of life on channels 1 and 2
  always @(negedge bus) begin
    if (arst_n) begin
      for (int i = 0; i < CHN; i++) begin
        if (trg_out[i]) trg_cnt[i]++;
        if (i != 0 && (trg_out[i] || dac_vld[i])) other_act++;
      end
    end
  end

  initial begin
    cyc = 0;
    while (cyc < MAX_CYC) begin
      @(posedge bus);
      cyc++;
    end
    $display("run did not finish within %0d cycles", MAX_CYC);
    $display("TEST FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
    end
    return r;
  endfunction

  function automatic logic [31:0] field(input logic [31:0] v, input int w, input bit sgn);
    logic [31:0] m;
    m = (w >= 32) ? '1 : (32'h1 << w) - 32'h1;
    return (sgn && v[w-1]) ? (v | ~m) : (v & m);  // sign extend or mask
  endfunction

  function automatic logic [31:0] reg_exp(input logic [RAW-1:0] off, input logic [31:0] v);
    case (off)
      REG_TRG:                   return field(v, TN, 0);
      REG_SIZ, REG_OFF, REG_STP: return field(v, CWM + CWF, 0);
      REG_BST:                   return field(v, 2, 0);
      REG_BDL:                   return field(v, CWM, 0);
      REG_BNM:                   return field(v, 16, 0);
      REG_MUL, REG_SUM:          return field(v, DW, 1);
      default:                   return v;  // bln is a full word
    endcase
  endfunction

  // gain, shift, offset, clamp
  function automatic int lin_exp(input int v, input int mul, input int sum);
    int r;
    r = ((v * mul) >>> (DW - 2)) + sum;
    if (r > 2**(DW-1) - 1) r = 2**(DW-1) - 1;
    if (r < -(2**(DW-1))) r = -(2**(DW-1));
    return r;
  endfunction

  function automatic logic [AW-1:0] reg_adr(input int ch, input logic [RAW-1:0] off);
    return AW'(ch << (CWM + 3)) | AW'(off);
  endfunction

  function automatic logic [AW-1:0] tbl_adr(input int ch, input int w);
    return AW'((ch << (CWM + 3)) | (1 << (CWM + 2)) | (w << 2));
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_chk++;
    assert (act === exp) else begin
      n_err++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    n_chk++;
    assert (ok) else begin
      n_err++;
      $display("%0t %s", $time, what);
    end
  endtask

  task automatic bus_write(input logic [AW-1:0] addr, input logic [31:0] data);
    @(negedge bus);
    bus_addr  = addr;
    bus_wdata = data;
    bus_wen   = 1'b1;
    @(negedge bus);
    bus_wen = 1'b0;
    check_val("bus_ack", 1, bus_ack);  // exactly one cycle later
  endtask

  task automatic bus_read(input logic [AW-1:0] addr, output logic [31:0] data);
    @(negedge bus);
    bus_addr = addr;
    bus_ren  = 1'b1;
    @(negedge bus);
    bus_ren = 1'b0;
    check_val("bus_ack", 1, bus_ack);
    data = bus_rdata;
  endtask

  task automatic read_check(input logic [AW-1:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] d;
    bus_read(addr, d);
    check_val(name, exp, d);
  endtask

  task automatic setup(input int ch, input int n, input int off, input int stp,
                       input int mul, input int sum, input int bst);
    bus_write(reg_adr(ch, REG_SIZ), n << CWF);  // integer size
    bus_write(reg_adr(ch, REG_OFF), off);
    bus_write(reg_adr(ch, REG_STP), stp);
    bus_write(reg_adr(ch, REG_MUL), mul);
    bus_write(reg_adr(ch, REG_SUM), sum);
    bus_write(reg_adr(ch, REG_BST), bst);
    exp_dat.delete();
    exp_vld.delete();
  endtask

  // channel 0 stream from word k, each word repeated 2**shr times
  task automatic push_play(input int n, input int k, input int shr, input int mul,
                           input int sum, input int cnt);
    for (int i = 0; i < cnt; i++) begin
      exp_dat.push_back(DW'(lin_exp(tbl_mdl[0][(k + (i >> shr)) % n], mul, sum)));
      exp_vld.push_back(1'b1);
    end
  endtask

  // first valid word, then cycle by cycle against the queues
  task automatic check_stream(input int ch);
    int t;
    t = 0;
    while (!dac_vld[ch] && t < 32) begin
      @(negedge bus);
      t++;
    end
    check_true(dac_vld[ch], "no valid DAC word after the trigger");
    for (int i = 0; i < exp_dat.size(); i++) begin
      check_val("dac_vld", exp_vld[i], dac_vld[ch]);
      check_val("dac_dat", exp_dat[i], dac_dat[ch]);
      @(negedge bus);
    end
  endtask

  task automatic stop_ch(input int ch);
    int t;
    t = 0;
    bus_write(reg_adr(ch, REG_CTL), 32'h1);  // software rst
    while (dac_vld[ch] && t < 8) begin
      @(negedge bus);
      t++;
    end
    check_true(!dac_vld[ch], "DAC output still valid after the software reset");
    read_check(reg_adr(ch, REG_CTL), 32'h8, "ctl status");  // not running
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_access();
    logic [31:0] wv [10];
    logic [31:0] tv [2**CWM];
    for (int ch = 0; ch < CHN; ch++) begin
      for (int r = 0; r < 10; r++) begin
        wv[r] = rand_bits(32);
        bus_write(reg_adr(ch, rw_regs[r]), wv[r]);
      end
      for (int w = 0; w < 2**CWM; w++) begin
        tv[w]          = rand_bits(32);
        tbl_mdl[ch][w] = tv[w][DW-1:0];
        bus_write(tbl_adr(ch, w), tv[w]);
      end
      for (int r = 0; r < 10; r++) begin
        read_check(reg_adr(ch, rw_regs[r]), reg_exp(rw_regs[r], wv[r]), "bus_rdata");
      end
      for (int w = 0; w < 2**CWM; w++) begin
        read_check(tbl_adr(ch, w), field(tv[w], DW, 1), "bus_rdata");
      end
      bus_write(reg_adr(ch, REG_TRG), 0);  // quiet again, no mask, no burst
      bus_write(reg_adr(ch, REG_BST), 0);
    end
  endtask

  task automatic test_playback();
    int t0;
    t0 = trg_cnt[0];
    setup(0, 16, 0, 1 << CWF, UNITY, 0, 0);
    push_play(16, 0, 0, UNITY, 0, 36);  // over two table passes
    bus_write(reg_adr(0, REG_CTL), 32'h2);
    check_stream(0);
    stop_ch(0);
    check_val("trg_out[0] pulses", t0 + 1, trg_cnt[0]);
  endtask

  task automatic test_frac();
    setup(0, 20, 7 << CWF, 1 << (CWF - 1), UNITY, 0, 0);  // step 0.5
    push_play(20, 7, 1, UNITY, 0, 44);
    bus_write(reg_adr(0, REG_CTL), 32'h2);
    check_stream(0);
    stop_ch(0);
  endtask

  task automatic test_burst();
    logic [31:0] d;
    int t;
    setup(0, 16, 3 << CWF, 1 << CWF, UNITY, 0, 1);
    bus_write(reg_adr(0, REG_BDL), 5);
    bus_write(reg_adr(0, REG_BLN), 4);
    bus_write(reg_adr(0, REG_BNM), 3);
    bus_write(reg_adr(CHN, 0), 32'h3f);  // clear pending
    for (int r = 0; r < 3; r++) begin
      push_play(16, 3, 0, UNITY, 0, 5);
      for (int i = 0; i < 4 && r < 2; i++) begin  // idle gap
        exp_dat.push_back(DW'(0));
        exp_vld.push_back(1'b0);
      end
    end
    bus_write(reg_adr(0, REG_CTL), 32'h2);
    check_stream(0);
    t = 0;
    d = '0;
    while (!d[1] && t < 16) begin  // stp bit after the last gap
      bus_read(reg_adr(CHN, 0), d);
      t++;
    end
    check_val("irq pending", 32'h3, d);
    check_val("irq", 1, irq);
    bus_write(reg_adr(CHN, 0), 32'h3);
    read_check(reg_adr(CHN, 0), 0, "irq pending");
    check_val("irq", 0, irq);
    read_check(reg_adr(0, REG_STS_BNM), 3, "sts_bnm");
    read_check(reg_adr(0, REG_CTL), 32'h8, "ctl status");
  endtask

  task automatic test_gain();
    int gains [3] = '{8191, -4096, 3000};
    int sums [3]  = '{300, -1000, -7000};
    for (int j = 0; j < 3; j++) begin
      setup(0, 16, 0, 1 << CWF, gains[j], sums[j], 0);
      push_play(16, 0, 0, gains[j], sums[j], 20);
      bus_write(reg_adr(0, REG_CTL), 32'h2);
      check_stream(0);
      stop_ch(0);
    end
  endtask

  task automatic test_ext();
    int t0;
    setup(0, 16, 0, 1 << CWF, UNITY, 0, 0);
    push_play(16, 0, 0, UNITY, 0, 24);
    bus_write(reg_adr(0, REG_TRG), 32'h4);  // only trg_ext[2] counts
    bus_write(reg_adr(CHN, 0), 32'h3f);
    t0 = trg_cnt[0];
    trg_ext[0] = 1'b1;  // masked edge
    for (int i = 0; i < 12; i++) begin
      @(negedge bus);
      check_val("dac_vld[0]", 0, dac_vld[0]);
    end
    check_val("trg_out[0] pulses", t0, trg_cnt[0]);
    trg_ext[2] = 1'b1;
    check_stream(0);
    stop_ch(0);
    read_check(reg_adr(CHN, 0), 32'h1, "irq pending");  // trg only
    check_val("trg_out[0] pulses", t0 + 1, trg_cnt[0]);
    trg_ext = '0;
    bus_write(reg_adr(0, REG_TRG), 0);
  endtask

  initial begin
    bus       = 1'b0;
    arst_n    = 1'b0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    trg_ext   = '0;
    lfsr      = 32'h333d;
    n_chk     = 0;
    n_err     = 0;
    other_act = 0;
    for (int i = 0; i < CHN; i++) trg_cnt[i] = 0;
    rw_regs = '{REG_TRG, REG_SIZ, REG_OFF, REG_STP, REG_BST,
                REG_BDL, REG_BLN, REG_BNM, REG_MUL, REG_SUM};
    repeat (16) @(posedge bus);
    @(negedge bus);
    arst_n = 1'b1;
    check_val("dac_vld", 0, dac_vld);
    check_val("irq", 0, irq);
    read_check(reg_adr(0, REG_MUL), UNITY, "mul after reset");
    test_access();
    test_playback();
    test_frac();
    test_burst();
    test_gain();
    test_ext();
    check_true(other_act == 0, "channel 1 or 2 started although never triggered");
    $display("%0d checks, %0d errors", n_chk, n_err);
    if (n_err == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- sim.f
common/asg_pkg.sv
verilog/asg_bus_decode.sv
verilog/asg_bus_return.sv
asg_channel/asg_ch_regs.sv
asg_channel/asg_ch_gen.sv
asg_channel/asg_ch_lin.sv
asg_channel/asg_channel.sv
verilog/asg_top.sv
test/asg_asserts.sv
test/asg_tb.sv

//--- Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module asg_tb -f sim.f -Mdir obj_dir
	obj_dir/Vasg_tb > $(LOG) 2>&1; cat $(LOG)
	! grep -q "TEST FAIL" $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
